// ==== files.f ====
logic/dcache_pkg.sv
logic/cache_ram.sv
logic/line_store.sv
logic/xfer_counter.sv
logic/cache_ctrl.sv
logic/dcache_top.sv
tests/tb_mem.sv
tests/tb_dcache.sv

// ==== logic/cache_ctrl.sv ====
// Cache controller: request FSM, line buffer, eviction, refill and flush sequencing
`timescale 1ns/10ps

module cache_ctrl import dcache_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_i,
    // Core request and response
    input  logic   req_valid_i,
    output logic   req_ready_o,
    input  logic   req_we_i,
    input  addr_t  req_addr_i,
    input  word_t  req_wdata_i,
    input  be_t    req_be_i,
    output logic   resp_valid_o,
    input  logic   resp_ready_i,
    output word_t  resp_rdata_o,
    // Memory side
    output logic   mem_req_valid_o,
    input  logic   mem_req_ready_i,
    output logic   mem_req_we_o,
    output addr_t  mem_req_addr_o,
    output word_t  mem_req_wdata_o,
    input  logic   mem_rsp_valid_i,
    input  word_t  mem_rsp_rdata_i,
    // Flush handshake
    input  logic   flush_i,
    output logic   flush_ack_o,
    // Transfer counters
    output logic   clear_o,
    output logic   issue_o,
    output logic   receive_o,
    output logic   set_step_o,
    input  beat_t  issue_beat_i,
    input  beat_t  recv_beat_i,
    input  logic   issue_last_i,
    input  logic   recv_last_i,
    input  index_t set_i,
    input  logic   set_last_i,
    // Line store
    output logic   access_o,
    output logic   write_o,
    output logic   invalidate_o,
    output index_t index_o,
    output tag_t   tag_o,
    output logic   dirty_o,
    output line_t  line_o,
    input  logic   hit_i,
    input  logic   victim_valid_i,
    input  logic   victim_dirty_i,
    input  tag_t   victim_tag_i,
    input  line_t  line_i
);

    localparam int INDEX_LSB = BYTE_OFFSET + WORD_OFFSET;

    ctrl_state_t state_q, state_d;
    logic        flushing_q;
    logic        reads_issued_q;
    logic        flush_step;
    logic        req_we_q;
    addr_t       req_addr_q;
    word_t       req_wdata_q;
    be_t         req_be_q;
    tag_t        victim_tag_q;
    line_t       line_buf;
    beat_t       req_word;
    index_t      req_index;
    tag_t        req_tag;
    index_t      mem_index;
    tag_t        mem_tag;

    assign req_word  = req_addr_q[BYTE_OFFSET +: WORD_OFFSET];
    assign req_index = req_addr_q[INDEX_LSB +: INDEX_WIDTH];
    assign req_tag   = req_addr_q[ADDR_WIDTH-1 -: TAG_WIDTH];

    // Store bytes land in the buffered line on the way into the array
    function automatic line_t merge_store(input line_t line_in);
        line_t merged;
        merged = line_in;
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (req_be_q[b]) begin
                merged[req_word][8*b +: 8] = req_wdata_q[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // ----------------------------------------
    // Line store addressing
    // ----------------------------------------
    always_comb begin
        if (state_q == IDLE) begin
            index_o = req_addr_i[INDEX_LSB +: INDEX_WIDTH];
            tag_o   = req_addr_i[ADDR_WIDTH-1 -: TAG_WIDTH];
        end else begin
            index_o = flushing_q ? set_i : req_index;
            tag_o   = req_tag;
        end
    end

    always_comb begin
        line_o = req_we_q ? merge_store(line_buf) : line_buf;
    end

    // ----------------------------------------
    // Memory port
    // ----------------------------------------
    // Evictions go to the victim's address, refills to the request's
    assign mem_index       = flushing_q ? set_i : req_index;
    assign mem_tag         = (state_q == EVICT) ? victim_tag_q : req_tag;
    assign mem_req_addr_o  = {mem_tag, mem_index, issue_beat_i, {BYTE_OFFSET{1'b0}}};
    assign mem_req_wdata_o = line_buf[issue_beat_i];
    assign resp_rdata_o    = line_buf[req_word];
    assign req_ready_o     = (state_q == IDLE) && !flush_i;

    // ----------------------------------------
    // Next state and strobes
    // ----------------------------------------
    always_comb begin
        state_d         = state_q;
        flush_step      = 1'b0;
        resp_valid_o    = 1'b0;
        mem_req_valid_o = 1'b0;
        mem_req_we_o    = 1'b0;
        flush_ack_o     = 1'b0;
        clear_o         = 1'b0;
        issue_o         = 1'b0;
        receive_o       = 1'b0;
        access_o        = 1'b0;
        write_o         = 1'b0;
        dirty_o         = 1'b0;
        case (state_q)
            IDLE: begin
                if (flush_i) begin
                    clear_o = 1'b1;
                    state_d = FLUSH_READ;
                end else if (req_valid_i) begin
                    access_o = 1'b1;
                    state_d  = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit_i) begin
                    state_d = WRITE;
                end else begin
                    clear_o = 1'b1;
                    state_d = (victim_valid_i && victim_dirty_i) ? EVICT : REFILL;
                end
            end
            WRITE: begin
                // Only stores touch the array on a hit
                write_o = req_we_q;
                dirty_o = 1'b1;
                state_d = RESPOND;
            end
            RESPOND: begin
                resp_valid_o = 1'b1;
                if (resp_ready_i) begin
                    state_d = IDLE;
                end
            end
            EVICT: begin
                mem_req_valid_o = 1'b1;
                mem_req_we_o    = 1'b1;
                issue_o         = mem_req_ready_i;
                if (mem_req_ready_i && issue_last_i) begin
                    if (flushing_q) begin
                        flush_step = 1'b1;
                    end else begin
                        state_d = REFILL;
                    end
                end
            end
            REFILL: begin
                mem_req_valid_o = !reads_issued_q;
                issue_o         = !reads_issued_q && mem_req_ready_i;
                receive_o       = mem_rsp_valid_i;
                if (mem_rsp_valid_i && recv_last_i) begin
                    state_d = FILL_WRITE;
                end
            end
            FILL_WRITE: begin
                write_o = 1'b1;
                dirty_o = req_we_q;
                state_d = RESPOND;
            end
            FLUSH_READ: begin
                access_o = 1'b1;
                state_d  = FLUSH_CHECK;
            end
            FLUSH_CHECK: begin
                if (victim_valid_i && victim_dirty_i) begin
                    state_d = EVICT;
                end else begin
                    flush_step = 1'b1;
                end
            end
            FLUSH_DONE: begin
                flush_ack_o = 1'b1;
                state_d     = IDLE;
            end
            default: state_d = IDLE;
        endcase
        // Drop the current set and move on
        if (flush_step) begin
            state_d = set_last_i ? FLUSH_DONE : FLUSH_READ;
        end
    end

    assign invalidate_o = flush_step;
    assign set_step_o   = flush_step;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q        <= IDLE;
            flushing_q     <= 1'b0;
            reads_issued_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE && flush_i) begin
                flushing_q <= 1'b1;
            end else if (state_q == FLUSH_DONE) begin
                flushing_q <= 1'b0;
            end
            if (state_q != REFILL) begin
                reads_issued_q <= 1'b0;
            end else if (issue_o && issue_last_i) begin
                reads_issued_q <= 1'b1;
            end
        end
    end

    // Request and line buffer
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && req_valid_i && req_ready_o) begin
            req_we_q    <= req_we_i;
            req_addr_q  <= req_addr_i;
            req_wdata_q <= req_wdata_i;
            req_be_q    <= req_be_i;
        end
        if (state_q == LOOKUP || state_q == FLUSH_CHECK) begin
            line_buf     <= line_i;
            victim_tag_q <= victim_tag_i;
        end
        if (state_q == REFILL && mem_rsp_valid_i) begin
            line_buf[recv_beat_i] <= mem_rsp_rdata_i;
        end
    end

endmodule

// ==== logic/cache_ram.sv ====
// Single-port storage array with synchronous read, generic over its entry type
`timescale 1ns/10ps

module cache_ram import dcache_pkg::*; #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = NUM_SETS
) (
    input  logic   clk_i,
    input  logic   en_i,
    input  logic   we_i,
    input  index_t addr_i,
    input  entry_t wdata_i,
    output entry_t rdata_o
);

    entry_t mem [DEPTH];

    // Read data holds across writes and idle cycles
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

// ==== logic/dcache_pkg.sv ====
// Data cache package: address split, widths, storage entry types and controller states
package dcache_pkg;

    // ----------------------------------------
    // Geometry
    // ----------------------------------------
    localparam int ADDR_WIDTH     = 32;
    localparam int WORD_WIDTH     = 32;
    localparam int BYTES_PER_WORD = WORD_WIDTH / 8;
    localparam int LINE_WORDS     = 4;
    localparam int NUM_SETS       = 16;

    // Address fields, low to high
    localparam int BYTE_OFFSET = 2;
    localparam int WORD_OFFSET = 2;
    localparam int INDEX_WIDTH = 4;
    localparam int TAG_WIDTH   = ADDR_WIDTH - INDEX_WIDTH - WORD_OFFSET - BYTE_OFFSET;

    // ----------------------------------------
    // Types
    // ----------------------------------------
    typedef logic [WORD_WIDTH-1:0]     word_t;
    typedef logic [BYTES_PER_WORD-1:0] be_t;
    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [INDEX_WIDTH-1:0]    index_t;
    typedef logic [TAG_WIDTH-1:0]      tag_t;
    typedef logic [WORD_OFFSET-1:0]    beat_t;

    // Word 0 sits in the low bits
    typedef logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] line_t;

    typedef struct packed {
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    typedef enum logic [3:0] {
        IDLE, LOOKUP, WRITE, RESPOND, EVICT, REFILL, FILL_WRITE,
        FLUSH_READ, FLUSH_CHECK, FLUSH_DONE
    } ctrl_state_t;

endpackage

// ==== logic/dcache_top.sv ====
// Data cache top level: controller, transfer counters and line store
`timescale 1ns/10ps

module dcache_top import dcache_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  req_valid_i,
    output logic  req_ready_o,
    input  logic  req_we_i,
    input  addr_t req_addr_i,
    input  word_t req_wdata_i,
    input  be_t   req_be_i,
    output logic  resp_valid_o,
    input  logic  resp_ready_i,
    output word_t resp_rdata_o,
    output logic  mem_req_valid_o,
    input  logic  mem_req_ready_i,
    output logic  mem_req_we_o,
    output addr_t mem_req_addr_o,
    output word_t mem_req_wdata_o,
    input  logic  mem_rsp_valid_i,
    input  word_t mem_rsp_rdata_i,
    input  logic  flush_i,
    output logic  flush_ack_o
);

    // Counter handshake
    logic   clear, issue, receive, set_step;
    beat_t  issue_beat, recv_beat;
    logic   issue_last, recv_last, set_last;
    index_t set_idx;

    // Line store handshake
    logic   access, write, invalidate, dirty;
    index_t index;
    tag_t   tag, victim_tag;
    line_t  wr_line, rd_line;
    logic   hit, victim_valid, victim_dirty;

    cache_ctrl i_cache_ctrl (
        .clk_i, .rst_i,
        .req_valid_i, .req_ready_o, .req_we_i, .req_addr_i, .req_wdata_i, .req_be_i,
        .resp_valid_o, .resp_ready_i, .resp_rdata_o,
        .mem_req_valid_o, .mem_req_ready_i, .mem_req_we_o, .mem_req_addr_o,
        .mem_req_wdata_o, .mem_rsp_valid_i, .mem_rsp_rdata_i,
        .flush_i, .flush_ack_o,
        .clear_o ( clear ), .issue_o ( issue ), .receive_o ( receive ),
        .set_step_o ( set_step ), .issue_beat_i ( issue_beat ), .recv_beat_i ( recv_beat ),
        .issue_last_i ( issue_last ), .recv_last_i ( recv_last ),
        .set_i ( set_idx ), .set_last_i ( set_last ),
        .access_o ( access ), .write_o ( write ), .invalidate_o ( invalidate ),
        .index_o ( index ), .tag_o ( tag ), .dirty_o ( dirty ), .line_o ( wr_line ),
        .hit_i ( hit ), .victim_valid_i ( victim_valid ), .victim_dirty_i ( victim_dirty ),
        .victim_tag_i ( victim_tag ), .line_i ( rd_line )
    );

    xfer_counter i_xfer_counter (
        .clk_i, .rst_i,
        .clear_i ( clear ), .issue_i ( issue ), .receive_i ( receive ),
        .set_step_i ( set_step ), .issue_beat_o ( issue_beat ), .recv_beat_o ( recv_beat ),
        .issue_last_o ( issue_last ), .recv_last_o ( recv_last ),
        .set_o ( set_idx ), .set_last_o ( set_last )
    );

    line_store i_line_store (
        .clk_i, .rst_i,
        .access_i ( access ), .write_i ( write ), .invalidate_i ( invalidate ),
        .index_i ( index ), .tag_i ( tag ), .dirty_i ( dirty ), .line_i ( wr_line ),
        .hit_o ( hit ), .victim_valid_o ( victim_valid ), .victim_dirty_o ( victim_dirty ),
        .victim_tag_o ( victim_tag ), .line_o ( rd_line )
    );

endmodule

// ==== logic/line_store.sv ====
// Line store: tag and data arrays, per-set valid bits, hit and victim outputs
`timescale 1ns/10ps

module line_store import dcache_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_i,
    input  logic   access_i,
    input  logic   write_i,
    input  logic   invalidate_i,
    input  index_t index_i,
    input  tag_t   tag_i,
    input  logic   dirty_i,
    input  line_t  line_i,
    output logic   hit_o,
    output logic   victim_valid_o,
    output logic   victim_dirty_o,
    output tag_t   victim_tag_o,
    output line_t  line_o
);

    logic [NUM_SETS-1:0] valid_q;
    logic                valid_rd_q;
    tag_t                tag_cmp_q;
    tag_entry_t          tag_wr;
    tag_entry_t          tag_rd;
    logic                ram_en;

    assign ram_en = access_i | write_i;
    assign tag_wr = '{dirty: dirty_i, tag: tag_i};

    cache_ram #(
        .entry_t ( tag_entry_t ),
        .DEPTH   ( NUM_SETS    )
    ) tag_ram (
        .clk_i   ( clk_i       ),
        .en_i    ( ram_en      ),
        .we_i    ( write_i     ),
        .addr_i  ( index_i     ),
        .wdata_i ( tag_wr      ),
        .rdata_o ( tag_rd      )
    );

    cache_ram #(
        .entry_t ( line_t      ),
        .DEPTH   ( NUM_SETS    )
    ) data_ram (
        .clk_i   ( clk_i       ),
        .en_i    ( ram_en      ),
        .we_i    ( write_i     ),
        .addr_i  ( index_i     ),
        .wdata_i ( line_i      ),
        .rdata_o ( line_o      )
    );

    // Valid bits live in flops so reset can clear them
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q    <= '0;
            valid_rd_q <= 1'b0;
        end else begin
            if (invalidate_i) begin
                valid_q[index_i] <= 1'b0;
            end else if (write_i) begin
                valid_q[index_i] <= 1'b1;
            end
            if (access_i) begin
                valid_rd_q <= valid_q[index_i];
            end
        end
    end

    // Compare tag lines up with the array read
    always_ff @(posedge clk_i) begin
        if (access_i) begin
            tag_cmp_q <= tag_i;
        end
    end

    assign hit_o          = valid_rd_q && (tag_rd.tag == tag_cmp_q);
    assign victim_valid_o = valid_rd_q;
    assign victim_dirty_o = tag_rd.dirty;
    assign victim_tag_o   = tag_rd.tag;

endmodule

// ==== logic/xfer_counter.sv ====
// Transfer counters: memory beats issued and received, and the flush set walk
`timescale 1ns/10ps

module xfer_counter import dcache_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_i,
    input  logic   clear_i,
    input  logic   issue_i,
    input  logic   receive_i,
    input  logic   set_step_i,
    output beat_t  issue_beat_o,
    output beat_t  recv_beat_o,
    output logic   issue_last_o,
    output logic   recv_last_o,
    output index_t set_o,
    output logic   set_last_o
);

    // Beat counters wrap back to zero after the last word of a line
    always_ff @(posedge clk_i) begin
        if (rst_i || clear_i) begin
            issue_beat_o <= '0;
            recv_beat_o  <= '0;
            set_o        <= '0;
        end else begin
            if (issue_i) begin
                issue_beat_o <= issue_beat_o + 1'b1;
            end
            if (receive_i) begin
                recv_beat_o <= recv_beat_o + 1'b1;
            end
            if (set_step_i) begin
                set_o <= set_o + 1'b1;
            end
        end
    end

    assign issue_last_o = (issue_beat_o == beat_t'(LINE_WORDS - 1));
    assign recv_last_o  = (recv_beat_o == beat_t'(LINE_WORDS - 1));
    assign set_last_o   = (set_o == index_t'(NUM_SETS - 1));

endmodule

// ==== tests/tb_dcache.sv ====
// Data cache testbench: clock, reset, directed tests, shadow memory, watchdog and summary
`timescale 1ns/10ps

module tb_dcache import dcache_pkg::*;;

    localparam int CLK_PERIOD      = 40;
    localparam int MEM_WORDS       = 256;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 400;
    localparam int TIMEOUT_NS      = NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD;

    logic  clk_i, rst_i;
    logic  req_valid_i, req_ready_o, req_we_i;
    addr_t req_addr_i;
    word_t req_wdata_i;
    be_t   req_be_i;
    logic  resp_valid_o, resp_ready_i;
    word_t resp_rdata_o;
    logic  mem_req_valid_o, mem_req_ready_i, mem_req_we_o;
    addr_t mem_req_addr_o;
    word_t mem_req_wdata_o;
    logic  mem_rsp_valid_i;
    word_t mem_rsp_rdata_i;
    logic  flush_i, flush_ack_o;

    word_t shadow [MEM_WORDS];
    int    errors;
    int    tests_run;
    int    rd0, wr0, log0;

    dcache_top DUT (.*);

    tb_mem #(.DEPTH(MEM_WORDS)) MEM (
        .clk_i, .mem_req_valid_i(mem_req_valid_o), .mem_req_ready_o(mem_req_ready_i),
        .mem_req_we_i(mem_req_we_o), .mem_req_addr_i(mem_req_addr_o),
        .mem_req_wdata_i(mem_req_wdata_o), .mem_rsp_valid_o(mem_rsp_valid_i),
        .mem_rsp_rdata_o(mem_rsp_rdata_i)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp, logic [31:0] got);
        $display("FAILED %s: expected %h, got %h", name, exp, got);
        errors++;
    endtask

    function automatic word_t merge_bytes(input word_t old, input word_t wdata, input be_t be);
        word_t r;
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            r[8*i +: 8] = be[i] ? wdata[8*i +: 8] : old[8*i +: 8];
        end
        return r;
    endfunction

    function automatic word_t shadow_word(input addr_t addr);
        return shadow[(addr >> 2) % MEM_WORDS];
    endfunction

    task automatic store_shadow(input addr_t addr, input word_t wdata, input be_t be);
        shadow[(addr >> 2) % MEM_WORDS] = merge_bytes(shadow_word(addr), wdata, be);
    endtask

    task automatic check_load(input addr_t addr, input word_t rdata);
        if (rdata !== shadow_word(addr)) begin
            report_mismatch("resp_rdata_o", shadow_word(addr), rdata);
        end
    endtask

    task automatic snapshot();
        rd0  = MEM.rd_count;
        wr0  = MEM.wr_count;
        log0 = MEM.beat_count;
    endtask

    task automatic check_counts(input int exp_rd, input int exp_wr);
        if (MEM.rd_count - rd0 != exp_rd) begin
            report_mismatch("read beats", exp_rd, MEM.rd_count - rd0);
        end
        if (MEM.wr_count - wr0 != exp_wr) begin
            report_mismatch("write beats", exp_wr, MEM.wr_count - wr0);
        end
    endtask

    // One line of beats in address order from log entry first
    task automatic check_line_beats(input int first, input logic we, input addr_t base);
        int idx;
        for (int i = 0; i < LINE_WORDS; i++) begin
            idx = (first + i) % 256;
            if (MEM.beat_we[idx] !== we) begin
                report_mismatch("mem_req_we_o", we, MEM.beat_we[idx]);
            end
            if (MEM.beat_addr[idx] !== base + 4 * i) begin
                report_mismatch("mem_req_addr_o", base + 4 * i, MEM.beat_addr[idx]);
            end
        end
    endtask

    // Memory words at index first and up must match the shadow copy
    task automatic check_memory(input int first, input int count);
        for (int i = first; i < first + count; i++) begin
            if (MEM.mem[i] !== shadow[i]) begin
                report_mismatch("mem_req_wdata_o", shadow[i], MEM.mem[i]);
            end
        end
    endtask

    // Full request and response; hold keeps resp_ready_i low for that many cycles
    task automatic access(input logic we, input addr_t addr, input word_t wdata, input be_t be,
                          input int hold, output word_t rdata, output int latency);
        logic rdy;
        req_valid_i  = 1'b1;
        req_we_i     = we;
        req_addr_i   = addr;
        req_wdata_i  = wdata;
        req_be_i     = be;
        resp_ready_i = (hold == 0);
        rdy          = 1'b0;
        while (!rdy) begin
            #1;
            rdy = req_ready_o;
            next_cycle();
        end
        req_valid_i = 1'b0;
        latency     = 0;
        while (!resp_valid_o) begin
            next_cycle();
            latency++;
        end
        rdata = resp_rdata_o;
        for (int i = 0; i < hold; i++) begin
            next_cycle();
            if (resp_valid_o !== 1'b1) report_mismatch("resp_valid_o", 1, resp_valid_o);
            if (resp_rdata_o !== rdata) report_mismatch("resp_rdata_o", rdata, resp_rdata_o);
            if (req_ready_o !== 1'b0) report_mismatch("req_ready_o", 0, req_ready_o);
        end
        resp_ready_i = 1'b1;
        next_cycle();
    endtask

    task automatic run_flush(output int acks);
        flush_i = 1'b1;
        acks    = 0;
        while (acks == 0) begin
            next_cycle();
            if (flush_ack_o) acks++;
        end
        flush_i = 1'b0;
        repeat (4) begin
            next_cycle();
            if (flush_ack_o) acks++;
        end
    endtask

    task automatic finish_test(input string name, input int e0);
        tests_run++;
        if (errors == e0) $display("%s: passed", name);
        else $display("%s: %0d error(s)", name, errors - e0);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_cold_load();
        word_t rdata;
        int    lat, e0;
        e0 = errors;
        snapshot();
        access(1'b0, 32'h048, '0, 4'hf, 0, rdata, lat);
        check_load(32'h048, rdata);
        check_counts(4, 0);
        check_line_beats(log0, 1'b0, 32'h040);
        snapshot();
        access(1'b0, 32'h04c, '0, 4'hf, 0, rdata, lat);
        check_load(32'h04c, rdata);
        if (lat != 2) report_mismatch("resp_valid_o latency", 2, lat);
        check_counts(0, 0);
        finish_test("cold load", e0);
    endtask

    task automatic test_store_hit();
        word_t rdata, expected;
        int    lat, e0;
        e0       = errors;
        expected = merge_bytes(shadow_word(32'h044), 32'ha5c3_5a3c, 4'b0101);
        snapshot();
        access(1'b1, 32'h044, 32'ha5c3_5a3c, 4'b0101, 0, rdata, lat);
        store_shadow(32'h044, 32'ha5c3_5a3c, 4'b0101);
        if (lat != 2) report_mismatch("resp_valid_o latency", 2, lat);
        access(1'b0, 32'h044, '0, 4'hf, 0, rdata, lat);
        if (rdata !== expected) report_mismatch("resp_rdata_o", expected, rdata);
        check_counts(0, 0);
        finish_test("store hit", e0);
    endtask

    task automatic test_evict();
        word_t rdata;
        int    lat, e0;
        e0 = errors;
        snapshot();
        access(1'b0, 32'h144, '0, 4'hf, 0, rdata, lat);
        check_load(32'h144, rdata);
        check_counts(4, 4);
        check_line_beats(log0, 1'b1, 32'h040);
        check_line_beats(log0 + LINE_WORDS, 1'b0, 32'h140);
        check_memory(16, LINE_WORDS);
        snapshot();
        access(1'b0, 32'h044, '0, 4'hf, 0, rdata, lat);
        check_load(32'h044, rdata);
        check_counts(4, 0);
        check_line_beats(log0, 1'b0, 32'h040);
        finish_test("dirty eviction", e0);
    endtask

    task automatic test_flush();
        word_t rdata;
        int    lat, acks, e0;
        e0 = errors;
        snapshot();
        access(1'b1, 32'h2c8, 32'h1357_9bdf, 4'b1100, 0, rdata, lat);
        store_shadow(32'h2c8, 32'h1357_9bdf, 4'b1100);
        check_counts(4, 0);
        check_line_beats(log0, 1'b0, 32'h2c0);
        access(1'b1, 32'h040, 32'h0bad_f00d, 4'b1111, 0, rdata, lat);
        store_shadow(32'h040, 32'h0bad_f00d, 4'b1111);
        // Sets 4 and 12 are dirty and go back in set order
        snapshot();
        run_flush(acks);
        if (acks != 1) report_mismatch("flush_ack_o pulses", 1, acks);
        check_counts(0, 2 * LINE_WORDS);
        check_line_beats(log0, 1'b1, 32'h040);
        check_line_beats(log0 + LINE_WORDS, 1'b1, 32'h2c0);
        check_memory(0, MEM_WORDS);
        snapshot();
        access(1'b0, 32'h2c8, '0, 4'hf, 0, rdata, lat);
        check_load(32'h2c8, rdata);
        check_counts(4, 0);
        check_line_beats(log0, 1'b0, 32'h2c0);
        finish_test("flush", e0);
    endtask

    task automatic test_backpressure();
        word_t rdata;
        int    lat, e0;
        e0 = errors;
        snapshot();
        access(1'b0, 32'h388, '0, 4'hf, 6, rdata, lat);
        check_load(32'h388, rdata);
        check_counts(4, 0);
        check_line_beats(log0, 1'b0, 32'h380);
        access(1'b1, 32'h38c, 32'h6e6f_7721, 4'b0011, 3, rdata, lat);
        store_shadow(32'h38c, 32'h6e6f_7721, 4'b0011);
        access(1'b0, 32'h38c, '0, 4'hf, 4, rdata, lat);
        check_load(32'h38c, rdata);
        check_counts(4, 0);
        finish_test("response back-pressure", e0);
    endtask

    // ----------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------
    initial begin
        clk_i        = 1'b0;
        rst_i        = 1'b1;
        req_valid_i  = 1'b0;
        req_we_i     = 1'b0;
        req_addr_i   = '0;
        req_wdata_i  = '0;
        req_be_i     = '0;
        resp_ready_i = 1'b1;
        flush_i      = 1'b0;
        errors       = 0;
        tests_run    = 0;
        repeat (3) @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = MEM.mem[i];
        end
        next_cycle();
        test_cold_load();
        test_store_hit();
        test_evict();
        test_flush();
        test_backpressure();
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within the cycle budget");
        $display("Errors found");
        $finish;
    end

endmodule

// ==== tests/tb_mem.sv ====
// Memory model: random-filled word array, random ready, in-order read return, beat log
`timescale 1ns/10ps

module tb_mem import dcache_pkg::*; #(
    parameter int DEPTH = 256
) (
    input  logic  clk_i,
    input  logic  mem_req_valid_i,
    output logic  mem_req_ready_o,
    input  logic  mem_req_we_i,
    input  addr_t mem_req_addr_i,
    input  word_t mem_req_wdata_i,
    output logic  mem_rsp_valid_o,
    output word_t mem_rsp_rdata_o
);

    localparam logic [31:0] SEED    = 32'd99115;
    localparam logic [31:0] TAPS    = 32'h8020_0003;
    localparam int          LATENCY = 2;
    localparam int          LOG_DEPTH = 256;

    word_t       mem [DEPTH];
    logic [31:0] lfsr_q;
    logic [31:0] ready_bits;
    logic        pipe_valid [LATENCY];
    word_t       pipe_data [LATENCY];

    // Beat log in issue order for the testbench
    addr_t beat_addr [LOG_DEPTH];
    logic  beat_we [LOG_DEPTH];
    int    beat_count;
    int    rd_count;
    int    wr_count;

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ TAPS) : (lfsr_q >> 1);
        end
        return r;
    endfunction

    initial begin
        lfsr_q          = SEED;
        beat_count      = 0;
        rd_count        = 0;
        wr_count        = 0;
        mem_req_ready_o = 1'b0;
        mem_rsp_valid_o = 1'b0;
        mem_rsp_rdata_o = '0;
        for (int i = 0; i < LATENCY; i++) begin
            pipe_valid[i] = 1'b0;
            pipe_data[i]  = '0;
        end
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = lfsr_bits(WORD_WIDTH);
        end
    end

    always @(posedge clk_i) begin
        for (int i = LATENCY - 1; i > 0; i--) begin
            pipe_valid[i] = pipe_valid[i-1];
            pipe_data[i]  = pipe_data[i-1];
        end
        pipe_valid[0] = 1'b0;
        if (mem_req_valid_i && mem_req_ready_o) begin
            beat_addr[beat_count % LOG_DEPTH] = mem_req_addr_i;
            beat_we[beat_count % LOG_DEPTH]   = mem_req_we_i;
            beat_count++;
            if (mem_req_we_i) begin
                mem[(mem_req_addr_i >> 2) % DEPTH] = mem_req_wdata_i;
                wr_count++;
            end else begin
                pipe_valid[0] = 1'b1;
                pipe_data[0]  = mem[(mem_req_addr_i >> 2) % DEPTH];
                rd_count++;
            end
        end
        // Outputs change a little after the edge
        #2;
        mem_rsp_valid_o = pipe_valid[LATENCY-1];
        mem_rsp_rdata_o = pipe_data[LATENCY-1];
        ready_bits      = lfsr_bits(1);
        mem_req_ready_o = ready_bits[0];
    end

endmodule
